// File: compile.f
+incdir+hw
hw/link_pkg.sv
hw/link_fifo.sv
hw/link_dispatch.sv
hw/link_endpoint.sv
hw/link_collect.sv
hw/link_hub.sv
tb/link_hub_tb.sv

// File: hw/link_collect.sv
`default_nettype none
`include "link_defines.svh"

module link_collect
  import link_pkg::*;
(
  input  wire                                    clk,
  input  wire                                    rst_n,
  input  wire             [`LINK_NUM_LANES-1:0] recv_valid,
  input  wire link_word_t [`LINK_NUM_LANES-1:0] recv_word,
  output logic                                   rx_valid,
  output link_rx_ind_t                           rx_ind,
  output logic                                   rx_overflow
);

  localparam int N = `LINK_NUM_LANES;

  logic [N-1:0] q_push;
  logic [N-1:0] q_pop;
  logic [N-1:0] q_empty;
  logic [N-1:0] q_full;
  link_word_t   q_data [N];
  lane_t        last;
  lane_t        sel;
  logic         found;

  for (genvar i = 0; i < N; i++) begin : g_q
    assign q_push[i] = recv_valid[i] && !q_full[i];
    assign q_pop[i]  = found && (sel == lane_t'(i));

    link_fifo #(
      .payload_t (link_word_t),
      .DEPTH     (`LINK_RXQ_DEPTH)
    ) u_rxq (
      .clk       (clk),
      .rst_n     (rst_n),
      .push      (q_push[i]),
      .push_data (recv_word[i]),
      .pop       (q_pop[i]),
      .pop_data  (q_data[i]),
      .empty     (q_empty[i]),
      .full      (q_full[i])
    );
  end

  // Search starts one past the lane served last
  always_comb begin
    int idx;
    found = 1'b0;
    sel   = last;
    for (int k = 1; k <= N; k++) begin
      idx = (int'(last) + k) % N;
      if (!found && !q_empty[idx]) begin
        found = 1'b1;
        sel   = lane_t'(idx);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_valid    <= 1'b0;
      rx_overflow <= 1'b0;
      last        <= lane_t'(N - 1); // Lane 0 goes first
    end else begin
      rx_valid <= found;
      if (found) last <= sel;
      if (|(recv_valid & q_full)) rx_overflow <= 1'b1; // Word dropped
    end
  end

  always_ff @(posedge clk) begin
    if (found) begin
      rx_ind.lane <= sel;
      rx_ind.word <= q_data[sel];
    end
  end

endmodule

`default_nettype wire

// File: hw/link_defines.svh
`ifndef LINK_DEFINES_SVH
`define LINK_DEFINES_SVH

// Must be even since lanes are cross-wired in pairs
`define LINK_NUM_LANES 2
`define LINK_DATA_W    38
`define LINK_TXQ_DEPTH 4
`define LINK_RXQ_DEPTH 4
// Counter wraps every 32 cycles
`define LINK_DWELL     5

`endif

// File: hw/link_dispatch.sv
`default_nettype none
`include "link_defines.svh"

module link_dispatch
  import link_pkg::*;
(
  input  wire                             clk,
  input  wire                             rst_n,
  input  wire                             tx_valid,
  input  wire link_tx_req_t               tx_req,
  output logic                            tx_ready,
  input  wire        [`LINK_NUM_LANES-1:0] send_idle,
  output logic       [`LINK_NUM_LANES-1:0] send_valid,
  output link_word_t                      send_word
);

  link_tx_req_t head;
  logic         q_push;
  logic         q_pop;
  logic         q_empty;
  logic         q_full;

  // Empty requests never enter the queue
  assign q_push   = tx_valid && !q_full && (tx_req.word.kind != KIND_NONE);
  assign tx_ready = !q_full;

  // Head blocks until its lane is trained and idle
  assign q_pop     = !q_empty && send_idle[head.lane];
  assign send_word = head.word;

  always_comb begin
    send_valid = '0;
    if (q_pop) send_valid[head.lane] = 1'b1;
  end

  link_fifo #(
    .payload_t (link_tx_req_t),
    .DEPTH     (`LINK_TXQ_DEPTH)
  ) u_txq (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (q_push),
    .push_data (tx_req),
    .pop       (q_pop),
    .pop_data  (head),
    .empty     (q_empty),
    .full      (q_full)
  );

  a_one_lane: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(send_valid));

endmodule

`default_nettype wire

// File: hw/link_endpoint.sv
`default_nettype none
`include "link_defines.svh"

module link_endpoint
  import link_pkg::*;
(
  input  wire             clk,
  input  wire             rst_n,
  input  wire       [1:0] linkrx,
  output logic      [1:0] linktx,
  input  wire             master_sel,
  output logic            link_up,
  input  wire             send_valid,
  input  wire link_word_t send_word,
  output logic            send_idle,
  output logic            send_done,
  output logic            recv_valid,
  output link_word_t      recv_word
);

  typedef enum logic [3:0] {
    ST_IDLE, ST_DATA, ST_SYNC,
    ST_M0, ST_M1, ST_M2, ST_M3,
    ST_S0, ST_S1, ST_S2, ST_S3
  } send_state_t;

  typedef enum logic {RX_IDLE, RX_WORK} recv_state_t;

  send_state_t             state;
  recv_state_t             rx_state;
  logic [1:0]              rx_meta;
  logic [1:0]              rx_sync;
  logic [1:0]              rx_stable;
  logic [`LINK_DWELL-1:0]  dwell;
  logic                    tick;
  logic [4:0]              tx_cnt;
  logic [4:0]              rx_cnt;
  logic [`LINK_DATA_W-1:0] tx_shift;

  function automatic int dibit_count(input link_kind_t kind);
    case (kind)
      KIND_CMD:  return 19;
      KIND_RXS:  return 12;
      KIND_TXIQ: return 16;
      default:   return 0;
    endcase
  endfunction

  // Filter only moves when both sync stages agree
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_meta   <= 2'b00;
      rx_sync   <= 2'b00;
      rx_stable <= 2'b00;
    end else begin
      rx_meta <= linkrx;
      rx_sync <= rx_meta;
      if (rx_sync == rx_meta) rx_stable <= rx_sync;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) dwell <= '0;
    else        dwell <= dwell + 1'b1;
  end

  assign tick      = &dwell;
  assign link_up   = (state == ST_IDLE) || (state == ST_DATA) || (state == ST_SYNC);
  assign send_idle = (state == ST_IDLE);
  assign send_done = (state == ST_SYNC) && (tx_cnt == 5'd0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state  <= ST_S0;
      linktx <= 2'b00;
      tx_cnt <= '0;
    end else begin
      linktx <= 2'b00;
      case (state)
        ST_IDLE: begin
          if (send_valid && send_word.kind != KIND_NONE) begin
            linktx <= send_word.kind;
            tx_cnt <= 5'(dibit_count(send_word.kind) - 1);
            state  <= ST_DATA;
          end
        end
        ST_DATA: begin
          linktx <= tx_shift[`LINK_DATA_W-1 -: 2];
          if (tx_cnt == 5'd0) begin
            tx_cnt <= 5'd2; // Two idle dibits before done
            state  <= ST_SYNC;
          end else begin
            tx_cnt <= tx_cnt - 1'b1;
          end
        end
        ST_SYNC: begin
          if (tx_cnt == 5'd0) state <= ST_IDLE;
          else                tx_cnt <= tx_cnt - 1'b1;
        end
        // Master steps 10, 01, 11, 00 on dwell ticks
        ST_M0: begin
          linktx <= 2'b10;
          if (rx_stable == 2'b01 && tick) state <= ST_M1;
        end
        ST_M1: begin
          linktx <= 2'b01;
          case (rx_stable)
            2'b10:   if (tick) state <= ST_M2;
            2'b01:   if (tick) state <= ST_M0; // Stale answer
            default: state <= ST_M0;
          endcase
        end
        ST_M2: begin
          linktx <= 2'b11;
          case (rx_stable)
            2'b11:   if (tick) state <= ST_M3;
            2'b10:   if (tick) state <= ST_M0;
            default: state <= ST_M0;
          endcase
        end
        ST_M3: begin
          if (rx_stable == 2'b00)      state <= ST_IDLE;
          else if (rx_stable != 2'b11) state <= ST_M0;
        end
        // Slave mirrors each code until the line drops to 00
        ST_S0: begin
          if (master_sel)              state <= ST_M0;
          else if (rx_stable == 2'b10) state <= ST_S1;
        end
        ST_S1: begin
          linktx <= 2'b01;
          if (rx_stable == 2'b01)      state <= ST_S2;
          else if (rx_stable != 2'b10) state <= ST_S0;
        end
        ST_S2: begin
          linktx <= 2'b10;
          if (rx_stable == 2'b11)      state <= ST_S3;
          else if (rx_stable != 2'b01) state <= ST_S0;
        end
        ST_S3: begin
          linktx <= 2'b11;
          if (rx_stable == 2'b00)      state <= ST_IDLE;
          else if (rx_stable != 2'b11) state <= ST_S0;
        end
        default: state <= ST_S0;
      endcase
    end
  end

  // MSB of the meaningful field goes out first
  always_ff @(posedge clk) begin
    if (send_idle && send_valid)
      tx_shift <= send_word.data << (`LINK_DATA_W - 2 * dibit_count(send_word.kind));
    else if (state == ST_DATA)
      tx_shift <= tx_shift << 2;
  end

  always_ff @(posedge clk) begin
    if (!rst_n || !link_up) begin
      rx_state   <= RX_IDLE;
      rx_cnt     <= '0;
      recv_valid <= 1'b0;
    end else begin
      recv_valid <= 1'b0;
      case (rx_state)
        RX_IDLE: begin
          if (rx_meta != 2'b00) begin
            rx_cnt   <= 5'(dibit_count(link_kind_t'(rx_meta)) - 1);
            rx_state <= RX_WORK;
          end
        end
        RX_WORK: begin
          if (rx_cnt == 5'd0) begin
            recv_valid <= 1'b1;
            rx_state   <= RX_IDLE;
          end else begin
            rx_cnt <= rx_cnt - 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rx_state == RX_IDLE) begin
      recv_word.kind <= link_kind_t'(rx_meta);
      recv_word.data <= '0; // Zero fill above the field
    end else begin
      recv_word.data <= {recv_word.data[`LINK_DATA_W-3:0], rx_meta};
    end
  end

  a_send_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
    send_valid |-> send_idle);

endmodule

`default_nettype wire

// File: hw/link_fifo.sv
`default_nettype none

module link_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  wire           clk,
  input  wire           rst_n,
  input  wire           push,
  input  wire payload_t push_data,
  input  wire           pop,
  output payload_t      pop_data,
  output logic          empty,
  output logic          full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign do_push  = push && !full;
  assign do_pop   = pop && !empty;
  assign empty    = (count == '0);
  assign full     = (count == CNT_W'(DEPTH));
  assign pop_data = mem[rd_ptr]; // Head shown without a read cycle

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Callers are expected to check the flags themselves
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) !(push && full));
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) !(pop && empty));

endmodule

`default_nettype wire

// File: hw/link_hub.sv
`default_nettype none
`include "link_defines.svh"

module link_hub
  import link_pkg::*;
(
  input  wire                             clk,
  input  wire                             rst_n,
  input  wire                             tx_valid,
  input  wire link_tx_req_t               tx_req,
  output wire                             tx_ready,
  input  wire  [`LINK_NUM_LANES-1:0][1:0] linkrx,
  output wire  [`LINK_NUM_LANES-1:0][1:0] linktx,
  input  wire  [`LINK_NUM_LANES-1:0]      master_sel,
  output wire  [`LINK_NUM_LANES-1:0]      link_up,
  output wire                             rx_valid,
  output wire link_rx_ind_t               rx_ind,
  output wire                             rx_overflow
);

  localparam int N = `LINK_NUM_LANES;

  wire             [N-1:0] send_idle;
  wire             [N-1:0] send_valid;
  wire             [N-1:0] recv_valid;
  wire link_word_t         send_word;
  wire link_word_t [N-1:0] recv_word;

  link_dispatch u_dispatch (
    .clk        (clk),
    .rst_n      (rst_n),
    .tx_valid   (tx_valid),
    .tx_req     (tx_req),
    .tx_ready   (tx_ready),
    .send_idle  (send_idle),
    .send_valid (send_valid),
    .send_word  (send_word)
  );

  for (genvar i = 0; i < N; i++) begin : g_lane
    link_endpoint u_ep (
      .clk        (clk),
      .rst_n      (rst_n),
      .linkrx     (linkrx[i]),
      .linktx     (linktx[i]),
      .master_sel (master_sel[i]),
      .link_up    (link_up[i]),
      .send_valid (send_valid[i]),
      .send_word  (send_word),
      .send_idle  (send_idle[i]),
      .send_done  (),
      .recv_valid (recv_valid[i]),
      .recv_word  (recv_word[i])
    );
  end

  link_collect u_collect (
    .clk         (clk),
    .rst_n       (rst_n),
    .recv_valid  (recv_valid),
    .recv_word   (recv_word),
    .rx_valid    (rx_valid),
    .rx_ind      (rx_ind),
    .rx_overflow (rx_overflow)
  );

endmodule

`default_nettype wire

// File: hw/link_pkg.sv
`default_nettype none
`include "link_defines.svh"

package link_pkg;

  localparam int LANE_W = (`LINK_NUM_LANES > 1) ? $clog2(`LINK_NUM_LANES) : 1;

  typedef logic [LANE_W-1:0] lane_t;

  // Also the first dibit on the wire
  typedef enum logic [1:0] {
    KIND_NONE = 2'b00,
    KIND_CMD  = 2'b01,
    KIND_RXS  = 2'b10,
    KIND_TXIQ = 2'b11
  } link_kind_t;

  typedef struct packed {
    link_kind_t              kind;
    logic [`LINK_DATA_W-1:0] data; // Right-aligned
  } link_word_t;

  typedef struct packed {
    lane_t      lane; // Target lane
    link_word_t word;
  } link_tx_req_t;

  typedef struct packed {
    lane_t      lane; // Lane it arrived on
    link_word_t word;
  } link_rx_ind_t;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the link hub testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f compile.f --top-module link_hub_tb -o link_hub_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/link_hub_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "TB PASSED" <<< "$output"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: tb/link_hub_tb.sv
`default_nettype none
`include "link_defines.svh"

module link_hub_tb
  import link_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NL           = `LINK_NUM_LANES;
  localparam int NROWS        = 15;
  localparam int LINK_TIMEOUT = 3000;
  localparam int RX_TIMEOUT   = 500;
  localparam int QUIET_CYCLES = 200;

  typedef struct packed {
    lane_t                   src;
    link_kind_t              kind;
    logic [`LINK_DATA_W-1:0] data;
    lane_t                   exp_lane;
    logic [`LINK_DATA_W-1:0] exp_data;
    logic                    rnd;   // Data drawn at apply time
    logic                    burst; // Sent back to back with its neighbours
  } row_t;

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic                 tx_valid;
  link_tx_req_t         tx_req;
  logic [NL-1:0]        master_sel;
  wire                  tx_ready;
  wire  [NL-1:0][1:0]   linktx;
  wire  [NL-1:0][1:0]   linkrx;
  wire  [NL-1:0]        link_up;
  wire                  rx_valid;
  wire  link_rx_ind_t   rx_ind;
  wire                  rx_overflow;

  row_t   rows [NROWS];
  string  names [NROWS];
  int     nrows = 0;
  int     pending[$]; // Row indices still in flight
  integer seed;
  int     checks = 0;
  int     mismatches = 0;
  int     other_errs = 0;

  always #5 clk = ~clk;

  // Partner lanes cross-wired
  for (genvar k = 0; k < NL; k += 2) begin : g_pair
    assign linkrx[k+1] = linktx[k];
    assign linkrx[k]   = linktx[k+1];
  end

  link_hub uut (
    .clk         (clk),
    .rst_n       (rst_n),
    .tx_valid    (tx_valid),
    .tx_req      (tx_req),
    .tx_ready    (tx_ready),
    .linkrx      (linkrx),
    .linktx      (linktx),
    .master_sel  (master_sel),
    .link_up     (link_up),
    .rx_valid    (rx_valid),
    .rx_ind      (rx_ind),
    .rx_overflow (rx_overflow)
  );

  function automatic logic [`LINK_DATA_W-1:0] kind_mask(input link_kind_t kind);
    case (kind)
      KIND_CMD:  return '1;
      KIND_RXS:  return {{(`LINK_DATA_W-24){1'b0}}, {24{1'b1}}};
      KIND_TXIQ: return {{(`LINK_DATA_W-32){1'b0}}, {32{1'b1}}};
      default:   return '0;
    endcase
  endfunction

  task automatic add_row(input string name, input int src, input link_kind_t kind,
                         input logic [`LINK_DATA_W-1:0] data, input int exp_lane,
                         input logic [`LINK_DATA_W-1:0] exp_data, input bit rnd,
                         input bit burst);
    names[nrows]         = name;
    rows[nrows].src      = lane_t'(src);
    rows[nrows].kind     = kind;
    rows[nrows].data     = data;
    rows[nrows].exp_lane = lane_t'(exp_lane);
    rows[nrows].exp_data = exp_data;
    rows[nrows].rnd      = rnd;
    rows[nrows].burst    = burst;
    nrows++;
  endtask

  task automatic load_table();
    add_row("cmd_l0",      0, KIND_CMD,  38'h3F_1234_5678, 1, 38'h3F_1234_5678, 1'b0, 1'b0);
    add_row("cmd_l0_ones", 0, KIND_CMD,  38'h3F_FFFF_FFFF, 1, 38'h3F_FFFF_FFFF, 1'b0, 1'b0);
    add_row("rxs_l0",      0, KIND_RXS,  38'h3A_BCDE_F123, 1, 38'h00_00DE_F123, 1'b0, 1'b0);
    add_row("txiq_l0",     0, KIND_TXIQ, 38'h15_8765_4321, 1, 38'h00_8765_4321, 1'b0, 1'b0);
    add_row("cmd_l1",      1, KIND_CMD,  38'h01_0203_0405, 0, 38'h01_0203_0405, 1'b0, 1'b0);
    add_row("rxs_l1",      1, KIND_RXS,  38'h2F_FFFF_FFFF, 0, 38'h00_00FF_FFFF, 1'b0, 1'b0);
    add_row("txiq_l1",     1, KIND_TXIQ, 38'h3F_FFFF_FFFF, 0, 38'h00_FFFF_FFFF, 1'b0, 1'b0);
    add_row("rnd_rxs_l0",  0, KIND_RXS,  38'h0,            1, 38'h0,            1'b1, 1'b0);
    add_row("rnd_txiq_l1", 1, KIND_TXIQ, 38'h0,            0, 38'h0,            1'b1, 1'b0);
    add_row("rnd_cmd_l0",  0, KIND_CMD,  38'h0,            1, 38'h0,            1'b1, 1'b0);
    add_row("burst_a",     0, KIND_CMD,  38'h11_1111_1111, 1, 38'h11_1111_1111, 1'b0, 1'b1);
    add_row("burst_b",     1, KIND_RXS,  38'h22_2222_2222, 0, 38'h00_0022_2222, 1'b0, 1'b1);
    add_row("burst_c",     0, KIND_TXIQ, 38'h33_3333_3333, 1, 38'h00_3333_3333, 1'b0, 1'b1);
    add_row("burst_d",     0, KIND_RXS,  38'h04_4444_4444, 1, 38'h00_0044_4444, 1'b0, 1'b1);
    add_row("none_l0",     0, KIND_NONE, 38'h2A_AAAA_AAAA, 1, 38'h0,            1'b0, 1'b0);
  endtask

  task automatic wait_link_up();
    int n;
    n = 0;
    while (!(&link_up) && n < LINK_TIMEOUT) begin
      @(negedge clk);
      if (rx_valid) begin
        $display("rx_valid pulsed before all lanes were trained");
        other_errs++;
      end
      n++;
    end
    if (!(&link_up)) begin
      $display("Lanes not trained after %0d cycles, link_up = %b", LINK_TIMEOUT, link_up);
      other_errs++;
    end
  endtask

  task automatic send_row(input int i);
    logic [63:0] r;
    @(posedge clk);
    #1;
    if (rows[i].rnd) begin
      r = {$random(seed), $random(seed)};
      rows[i].data     = r[`LINK_DATA_W-1:0];
      rows[i].exp_data = rows[i].data & kind_mask(rows[i].kind);
    end
    if (!tx_ready) begin
      $display("%s: tx_ready was low when the request was strobed", names[i]);
      other_errs++;
    end
    tx_req.lane      = rows[i].src;
    tx_req.word.kind = rows[i].kind;
    tx_req.word.data = rows[i].data;
    tx_valid         = 1'b1;
    if (rows[i].kind != KIND_NONE) pending.push_back(i);
  endtask

  task automatic collect_one();
    int n;
    int hit;
    int idx;
    n   = 0;
    hit = -1;
    do begin
      @(negedge clk);
      n++;
    end while (!rx_valid && n < RX_TIMEOUT);
    if (!rx_valid) begin
      $display("No rx_valid within %0d cycles, %0d words lost", RX_TIMEOUT, pending.size());
      other_errs++;
      pending.delete();
    end else begin
      // Words for one lane must come back in the order they were sent
      foreach (pending[k]) begin
        if (hit < 0 && rows[pending[k]].exp_lane == rx_ind.lane) hit = k;
      end
      checks++;
      if (hit < 0) begin
        idx = pending[0];
        $display("FAIL %s lane: expected %0d actual %0d", names[idx],
                 rows[idx].exp_lane, rx_ind.lane);
        mismatches++;
        pending.delete(0);
      end else begin
        idx = pending[hit];
        pending.delete(hit);
        checks += 2;
        if (rx_ind.word.kind !== rows[idx].kind) begin
          $display("FAIL %s kind: expected %0d actual %0d", names[idx],
                   rows[idx].kind, rx_ind.word.kind);
          mismatches++;
        end
        if (rx_ind.word.data !== rows[idx].exp_data) begin
          $display("FAIL %s data: expected %h actual %h", names[idx],
                   rows[idx].exp_data, rx_ind.word.data);
          mismatches++;
        end
      end
    end
  endtask

  task automatic quiet_window(input string test);
    int n;
    bit seen;
    seen = 1'b0;
    for (n = 0; n < QUIET_CYCLES; n++) begin
      @(negedge clk);
      if (rx_valid) seen = 1'b1;
    end
    checks++;
    if (seen) begin
      $display("%s: a word arrived for a request that should have been dropped", test);
      other_errs++;
    end
  endtask

  initial begin
    seed     = 32'h63e7eafc;
    rst_n    = 1'b0;
    tx_valid = 1'b0;
    tx_req   = '0;
    for (int i = 0; i < NL; i++) master_sel[i] = (i % 2 == 0); // Even lanes lead training
    load_table();
    repeat (10) @(posedge clk);
    #1 rst_n = 1'b1;
    wait_link_up();

    for (int i = 0; i < nrows; i++) begin
      send_row(i);
      if (!rows[i].burst || i == nrows - 1 || !rows[i+1].burst) begin
        @(posedge clk);
        #1 tx_valid = 1'b0;
        if (rows[i].kind == KIND_NONE) quiet_window(names[i]);
        else while (pending.size() > 0) collect_one();
      end
    end

    checks++;
    if (rx_overflow) begin
      $display("rx_overflow was set during the run");
      other_errs++;
    end
    $display("Checks %0d, mismatches %0d, other errors %0d", checks, mismatches, other_errs);
    if (mismatches == 0 && other_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
